// File: design/rs_consts.svh
`ifndef RS_CONSTS_SVH
`define RS_CONSTS_SVH

// width of every operand, result and CDB data word
`define RS_XLEN 32

// reorder buffer tags are five bits wide
// tag 0 never names a producer, it means the operand value is already present
`define RS_TAG_WIDTH 5

// number of reservation station entries in the cluster
`define RS_ENTRIES 4

// shift amounts come from the low bits of operand 2
`define RS_SHAMT_WIDTH 5

`endif

// File: design/rs_pkg.sv
`default_nettype none

package rs_pkg;

	// ALU operations, encoded in three bits
	// the sign bit that travels with the opcode picks a signed compare for OP_SLT
	// and an arithmetic shift for OP_SR, every other opcode ignores it
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_SLL = 3'd2,
		OP_SLT = 3'd3,
		OP_XOR = 3'd4,
		OP_SR  = 3'd5,
		OP_OR  = 3'd6,
		OP_AND = 3'd7
	} alu_op_t;

endpackage

`default_nettype wire

// File: design/exec_if.sv
`default_nettype none
`timescale 1ns/1ps
`include "rs_consts.svh"

// carries one dispatched operation from the select block into the ALU
// an operation is taken on every rising edge that sees valid and accept both high
interface exec_if;
	import rs_pkg::*;

	// valid is a level that follows the ready entries only
	logic valid;

	// both operand values, already resolved to data
	logic [`RS_XLEN-1:0] v1;
	logic [`RS_XLEN-1:0] v2;

	logic op_sign;
	alu_op_t op;

	// reorder buffer tag under which the result goes out on the CDB
	logic [`RS_TAG_WIDTH-1:0] rob_tag;

	// driven by the ALU, low while a held result cannot leave
	logic accept;

	// the select block presents the operation
	modport src (
		output valid, v1, v2, op, op_sign, rob_tag,
		input accept
	);

	// the ALU consumes it
	modport dst (
		input valid, v1, v2, op, op_sign, rob_tag,
		output accept
	);

endinterface

`default_nettype wire

// File: design/reservation_station.sv
`default_nettype none
`timescale 1ns/1ps
`include "rs_consts.svh"

// one reservation station entry
// q is a pending tag and v is a value, tag 0 means the value is present
module reservation_station (
	input wire logic clk,
	input wire logic rst_n,

	// write strobe from the allocator and the dispatch pulse from the select block
	input wire logic enable,
	input wire logic dispatched_in,

	input wire logic [`RS_TAG_WIDTH-1:0] q1_in,
	input wire logic [`RS_XLEN-1:0] v1_in,
	input wire logic [`RS_TAG_WIDTH-1:0] q2_in,
	input wire logic [`RS_XLEN-1:0] v2_in,
	input wire rs_pkg::alu_op_t alu_op_in,
	input wire logic alu_sign_in,
	input wire logic [`RS_TAG_WIDTH-1:0] reorder_buffer_tag_in,

	input wire logic cdb_active,
	input wire logic [`RS_TAG_WIDTH-1:0] cdb_tag,
	input wire logic [`RS_XLEN-1:0] cdb_data,

	output logic [`RS_TAG_WIDTH-1:0] q1_out,
	output logic [`RS_XLEN-1:0] v1_out,
	output logic [`RS_TAG_WIDTH-1:0] q2_out,
	output logic [`RS_XLEN-1:0] v2_out,
	output rs_pkg::alu_op_t alu_op_out,
	output logic alu_sign_out,
	output logic [`RS_TAG_WIDTH-1:0] reorder_buffer_tag_out,

	output logic busy,
	output logic ready_to_execute
);

	// set once the ALU has taken this instruction, so it is not sent twice
	logic dispatched;

	logic snoop_op1;
	logic snoop_op2;
	logic free_self;

	// while being written the incoming tags are compared with the bus,
	// otherwise the stored ones, so a broadcast in the issue cycle is not lost
	// the bus never carries tag 0, so present operands never match
	assign snoop_op1 = cdb_active && ((enable ? q1_in : q1_out) == cdb_tag);
	assign snoop_op2 = cdb_active && ((enable ? q2_in : q2_out) == cdb_tag);

	// only this instruction can own its rob tag, so seeing it on the bus means we are done
	assign free_self = busy && cdb_active && (cdb_tag == reorder_buffer_tag_out);

	// ready comes from registered state only, one cycle after the last write or wake-up
	assign ready_to_execute = busy && !dispatched && (q1_out == '0) && (q2_out == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			dispatched <= 1'b0;
			q1_out <= '0;
			q2_out <= '0;
			reorder_buffer_tag_out <= '0;
		end else if (free_self) begin
			// clearing the tags keeps a stale entry from matching later broadcasts
			busy <= 1'b0;
			dispatched <= 1'b0;
			q1_out <= '0;
			q2_out <= '0;
			reorder_buffer_tag_out <= '0;
		end else begin
			if (enable) begin
				busy <= 1'b1;
				reorder_buffer_tag_out <= reorder_buffer_tag_in;
			end
			// a matched tag drops to 0, else take the issue tag on a write, else hold
			q1_out <= snoop_op1 ? '0 : (enable ? q1_in : q1_out);
			q2_out <= snoop_op2 ? '0 : (enable ? q2_in : q2_out);
			// the dispatched flag stays set until the entry frees itself
			if (dispatched_in)
				dispatched <= 1'b1;
		end
	end

	// operand values and the opcode are plain payload
	always_ff @(posedge clk) begin
		if (snoop_op1)
			v1_out <= cdb_data;
		else if (enable)
			v1_out <= v1_in;
		if (snoop_op2)
			v2_out <= cdb_data;
		else if (enable)
			v2_out <= v2_in;
		if (enable) begin
			alu_op_out <= alu_op_in;
			alu_sign_out <= alu_sign_in;
		end
	end

endmodule

`default_nettype wire

// File: design/rs_dispatch_select.sv
`default_nettype none
`timescale 1ns/1ps
`include "rs_consts.svh"

// allocates a free entry on issue and picks a ready entry for the ALU
module rs_dispatch_select (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic issue_valid,
	input wire logic [`RS_ENTRIES-1:0] busy,
	input wire logic [`RS_ENTRIES-1:0] ready,

	// stored contents of every entry
	input wire logic [`RS_XLEN-1:0] v1 [`RS_ENTRIES],
	input wire logic [`RS_XLEN-1:0] v2 [`RS_ENTRIES],
	input wire rs_pkg::alu_op_t op [`RS_ENTRIES],
	input wire logic [`RS_ENTRIES-1:0] sign,
	input wire logic [`RS_TAG_WIDTH-1:0] rob_tag [`RS_ENTRIES],

	output logic [`RS_ENTRIES-1:0] enable,
	output logic [`RS_ENTRIES-1:0] dispatched_pulse,
	output logic full,

	exec_if.src exec
);

	localparam int IDX_W = $clog2(`RS_ENTRIES);

	logic [IDX_W-1:0] low_idx;
	logic [IDX_W-1:0] sel_idx;
	logic [IDX_W-1:0] lock_idx;
	logic lock_valid;

	// issue is not allowed while every entry is busy
	assign full = &busy;

	// the lowest non-busy entry gets the write strobe
	always_comb begin : alloc
		logic found;
		found = 1'b0;
		enable = '0;
		for (int i = 0; i < `RS_ENTRIES; i++) begin
			if (!found && !busy[i]) begin
				enable[i] = issue_valid;
				found = 1'b1;
			end
		end
	end

	// lowest index ready entry
	always_comb begin : pick
		logic found;
		found = 1'b0;
		low_idx = '0;
		for (int i = 0; i < `RS_ENTRIES; i++) begin
			if (!found && ready[i]) begin
				low_idx = IDX_W'(i);
				found = 1'b1;
			end
		end
	end

	// an operation offered while the ALU stalls stays on the bus until it is taken,
	// so a lower entry waking up meanwhile does not swap the payload under it
	assign sel_idx = (lock_valid && ready[lock_idx]) ? lock_idx : low_idx;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			lock_valid <= 1'b0;
		else
			lock_valid <= exec.valid && !exec.accept;
	end

	always_ff @(posedge clk)
		lock_idx <= sel_idx;

	assign exec.valid = |ready;
	assign exec.v1 = v1[sel_idx];
	assign exec.v2 = v2[sel_idx];
	assign exec.op = op[sel_idx];
	assign exec.op_sign = sign[sel_idx];
	assign exec.rob_tag = rob_tag[sel_idx];

	// mark the chosen entry dispatched in the cycle the ALU takes it
	always_comb begin
		dispatched_pulse = '0;
		if (exec.valid && exec.accept)
			dispatched_pulse[sel_idx] = 1'b1;
	end

endmodule

`default_nettype wire

// File: design/alu_unit.sv
`default_nettype none
`timescale 1ns/1ps
`include "rs_consts.svh"

// single cycle ALU with a result register in front of the CDB
// the external producer always wins the bus, our result then waits in the register
module alu_unit (
	input wire logic clk,
	input wire logic rst_n,

	exec_if.dst exec,

	input wire logic ext_cdb_active,
	input wire logic [`RS_TAG_WIDTH-1:0] ext_cdb_tag,
	input wire logic [`RS_XLEN-1:0] ext_cdb_data,

	output logic cdb_active,
	output logic [`RS_TAG_WIDTH-1:0] cdb_tag,
	output logic [`RS_XLEN-1:0] cdb_data
);
	import rs_pkg::*;

	logic [`RS_XLEN-1:0] alu_result;
	logic [`RS_SHAMT_WIDTH-1:0] shamt;
	logic less_than;
	logic take;
	logic res_sent;

	// held result waiting for the bus
	logic res_valid;
	logic [`RS_TAG_WIDTH-1:0] res_tag;
	logic [`RS_XLEN-1:0] res_data;

	assign shamt = exec.v2[`RS_SHAMT_WIDTH-1:0];

	// signed or unsigned compare, chosen by the sign bit
	assign less_than = exec.op_sign ? ($signed(exec.v1) < $signed(exec.v2))
		: (exec.v1 < exec.v2);

	always_comb begin
		case (exec.op)
			OP_ADD: alu_result = exec.v1 + exec.v2;
			OP_SUB: alu_result = exec.v1 - exec.v2;
			OP_SLL: alu_result = exec.v1 << shamt;
			OP_SLT: alu_result = {{(`RS_XLEN-1){1'b0}}, less_than};
			OP_XOR: alu_result = exec.v1 ^ exec.v2;
			// arithmetic shift when signed, logical otherwise
			OP_SR: alu_result = exec.op_sign ? `RS_XLEN'($signed(exec.v1) >>> shamt)
				: (exec.v1 >> shamt);
			OP_OR: alu_result = exec.v1 | exec.v2;
			OP_AND: alu_result = exec.v1 & exec.v2;
			default: alu_result = '0;
		endcase
	end

	// the held result leaves in any cycle the external producer is quiet
	assign res_sent = res_valid && !ext_cdb_active;

	// a new operation fits when the register is empty or is being emptied right now
	assign exec.accept = !res_valid || !ext_cdb_active;
	assign take = exec.valid && exec.accept;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			res_valid <= 1'b0;
		else if (take)
			res_valid <= 1'b1;
		else if (res_sent)
			res_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			res_tag <= exec.rob_tag;
			res_data <= alu_result;
		end
	end

	// merged bus, external data first
	assign cdb_active = ext_cdb_active || res_valid;
	assign cdb_tag = ext_cdb_active ? ext_cdb_tag : res_tag;
	assign cdb_data = ext_cdb_active ? ext_cdb_data : res_data;

endmodule

`default_nettype wire

// File: design/alu_cluster.sv
`default_nettype none
`timescale 1ns/1ps
`include "rs_consts.svh"

// four reservation station entries feeding one ALU, all snooping one merged CDB
module alu_cluster (
	input wire logic clk,
	input wire logic rst_n,

	// issue port, shared by every entry
	input wire logic issue_valid,
	input wire logic [`RS_TAG_WIDTH-1:0] issue_q1,
	input wire logic [`RS_XLEN-1:0] issue_v1,
	input wire logic [`RS_TAG_WIDTH-1:0] issue_q2,
	input wire logic [`RS_XLEN-1:0] issue_v2,
	input wire rs_pkg::alu_op_t issue_op,
	input wire logic issue_sign,
	input wire logic [`RS_TAG_WIDTH-1:0] issue_rob_tag,
	output logic full,

	// external producer, such as a load unit
	input wire logic ext_cdb_active,
	input wire logic [`RS_TAG_WIDTH-1:0] ext_cdb_tag,
	input wire logic [`RS_XLEN-1:0] ext_cdb_data,

	// merged common data bus
	output logic cdb_active,
	output logic [`RS_TAG_WIDTH-1:0] cdb_tag,
	output logic [`RS_XLEN-1:0] cdb_data
);
	import rs_pkg::*;

	logic [`RS_ENTRIES-1:0] enable;
	logic [`RS_ENTRIES-1:0] dispatched_pulse;
	logic [`RS_ENTRIES-1:0] busy;
	logic [`RS_ENTRIES-1:0] ready;
	logic [`RS_ENTRIES-1:0] ent_sign;
	logic [`RS_XLEN-1:0] ent_v1 [`RS_ENTRIES];
	logic [`RS_XLEN-1:0] ent_v2 [`RS_ENTRIES];
	logic [`RS_TAG_WIDTH-1:0] ent_rob_tag [`RS_ENTRIES];
	alu_op_t ent_op [`RS_ENTRIES];

	exec_if exec_bus ();

	// the pending tags stay inside each entry, ready already folds them in
	for (genvar i = 0; i < `RS_ENTRIES; i++) begin : g_entry
		reservation_station entry_i (
			.clk                    (clk),
			.rst_n                  (rst_n),
			.enable                 (enable[i]),
			.dispatched_in          (dispatched_pulse[i]),
			.q1_in                  (issue_q1),
			.v1_in                  (issue_v1),
			.q2_in                  (issue_q2),
			.v2_in                  (issue_v2),
			.alu_op_in              (issue_op),
			.alu_sign_in            (issue_sign),
			.reorder_buffer_tag_in  (issue_rob_tag),
			.cdb_active             (cdb_active),
			.cdb_tag                (cdb_tag),
			.cdb_data               (cdb_data),
			.q1_out                 (),
			.v1_out                 (ent_v1[i]),
			.q2_out                 (),
			.v2_out                 (ent_v2[i]),
			.alu_op_out             (ent_op[i]),
			.alu_sign_out           (ent_sign[i]),
			.reorder_buffer_tag_out (ent_rob_tag[i]),
			.busy                   (busy[i]),
			.ready_to_execute       (ready[i])
		);
	end

	rs_dispatch_select select_i (
		.clk              (clk),
		.rst_n            (rst_n),
		.issue_valid      (issue_valid),
		.busy             (busy),
		.ready            (ready),
		.v1               (ent_v1),
		.v2               (ent_v2),
		.op               (ent_op),
		.sign             (ent_sign),
		.rob_tag          (ent_rob_tag),
		.enable           (enable),
		.dispatched_pulse (dispatched_pulse),
		.full             (full),
		.exec             (exec_bus.src)
	);

	alu_unit alu_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.exec           (exec_bus.dst),
		.ext_cdb_active (ext_cdb_active),
		.ext_cdb_tag    (ext_cdb_tag),
		.ext_cdb_data   (ext_cdb_data),
		.cdb_active     (cdb_active),
		.cdb_tag        (cdb_tag),
		.cdb_data       (cdb_data)
	);

endmodule

`default_nettype wire

// File: tb/alu_cluster_assert.sv
`default_nettype none
`timescale 1ns/1ps
`include "rs_consts.svh"

// protocol checks on the cluster's top level ports
module alu_cluster_assert (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic issue_valid,
	input wire logic [`RS_TAG_WIDTH-1:0] issue_rob_tag,
	input wire logic full,
	input wire logic ext_cdb_active,
	input wire logic [`RS_TAG_WIDTH-1:0] ext_cdb_tag,
	input wire logic [`RS_XLEN-1:0] ext_cdb_data,
	input wire logic cdb_active,
	input wire logic [`RS_TAG_WIDTH-1:0] cdb_tag,
	input wire logic [`RS_XLEN-1:0] cdb_data
);

	// issued rob tags whose result has not been on the CDB yet
	logic [(1 << `RS_TAG_WIDTH)-1:0] pending;
	logic alu_bcast;

	// failure counts, the testbench adds them to its own
	int full_issue_fails = 0;
	int zero_tag_fails = 0;
	int ext_pass_fails = 0;
	int reissue_fails = 0;
	int extra_bcast_fails = 0;

	// the ALU owns the bus only when the external producer is quiet
	assign alu_bcast = cdb_active && !ext_cdb_active;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= '0;
		end else begin
			if (alu_bcast)
				pending[cdb_tag] <= 1'b0;
			if (issue_valid)
				pending[issue_rob_tag] <= 1'b1;
		end
	end

	no_issue_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		!(issue_valid && full))
		else begin
			$error("issue while every entry is busy");
			full_issue_fails++;
		end

	// tag 0 means a present value, so no producer can broadcast it
	nonzero_cdb_tag: assert property (@(posedge clk) disable iff (!rst_n)
		cdb_active |-> (cdb_tag != '0))
		else begin
			$error("CDB active with tag 0");
			zero_tag_fails++;
		end

	ext_has_priority: assert property (@(posedge clk) disable iff (!rst_n)
		ext_cdb_active |-> (cdb_active && cdb_tag == ext_cdb_tag && cdb_data == ext_cdb_data))
		else begin
			$error("CDB does not carry the external producer's fields");
			ext_pass_fails++;
		end

	// a tag goes out once and only then may be issued again
	no_reissue_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
		issue_valid |-> !pending[issue_rob_tag])
		else begin
			$error("rob tag %0d issued again before its broadcast", issue_rob_tag);
			reissue_fails++;
		end

	alu_bcast_once: assert property (@(posedge clk) disable iff (!rst_n)
		alu_bcast |-> pending[cdb_tag])
		else begin
			$error("ALU broadcast of tag %0d that is not in flight", cdb_tag);
			extra_bcast_fails++;
		end

endmodule

`default_nettype wire

// File: tb/alu_cluster_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "rs_consts.svh"

module alu_cluster_tb;
	import rs_pkg::*;

	localparam int NTAGS = 1 << `RS_TAG_WIDTH;
	// six tests of up to about thirty cycles each, plus reset and drain margin
	localparam int TEST_CYCLES = 200;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic clk;
	logic rst_n;
	logic issue_valid;
	logic [`RS_TAG_WIDTH-1:0] issue_q1;
	logic [`RS_XLEN-1:0] issue_v1;
	logic [`RS_TAG_WIDTH-1:0] issue_q2;
	logic [`RS_XLEN-1:0] issue_v2;
	alu_op_t issue_op;
	logic issue_sign;
	logic [`RS_TAG_WIDTH-1:0] issue_rob_tag;
	logic full;
	logic ext_cdb_active;
	logic [`RS_TAG_WIDTH-1:0] ext_cdb_tag;
	logic [`RS_XLEN-1:0] ext_cdb_data;
	logic cdb_active;
	logic [`RS_TAG_WIDTH-1:0] cdb_tag;
	logic [`RS_XLEN-1:0] cdb_data;

	// reference model, expected value per rob tag and which tags are still in flight
	logic [`RS_XLEN-1:0] expected [NTAGS];
	logic [NTAGS-1:0] outstanding;
	int issue_cycle [NTAGS];
	int in_flight;
	logic [`RS_TAG_WIDTH-1:0] tag_counter;
	logic [31:0] rng_state;
	int cycle = 0;
	int errors;
	int pass_count;
	int fail_count;
	int test_errors_start;
	logic check_latency;
	string test_name;

	alu_cluster dut_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.issue_valid    (issue_valid),
		.issue_q1       (issue_q1),
		.issue_v1       (issue_v1),
		.issue_q2       (issue_q2),
		.issue_v2       (issue_v2),
		.issue_op       (issue_op),
		.issue_sign     (issue_sign),
		.issue_rob_tag  (issue_rob_tag),
		.full           (full),
		.ext_cdb_active (ext_cdb_active),
		.ext_cdb_tag    (ext_cdb_tag),
		.ext_cdb_data   (ext_cdb_data),
		.cdb_active     (cdb_active),
		.cdb_tag        (cdb_tag),
		.cdb_data       (cdb_data)
	);

	bind alu_cluster alu_cluster_assert assert_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.issue_valid    (issue_valid),
		.issue_rob_tag  (issue_rob_tag),
		.full           (full),
		.ext_cdb_active (ext_cdb_active),
		.ext_cdb_tag    (ext_cdb_tag),
		.ext_cdb_data   (ext_cdb_data),
		.cdb_active     (cdb_active),
		.cdb_tag        (cdb_tag),
		.cdb_data       (cdb_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// the run is cut off well past the point where every test should be done
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles", cycle);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	// tags count up and skip 0 when they wrap
	function automatic logic [`RS_TAG_WIDTH-1:0] alloc_tag();
		logic [`RS_TAG_WIDTH-1:0] t;
		t = tag_counter;
		tag_counter = (tag_counter == '1) ? `RS_TAG_WIDTH'(1) : tag_counter + 1'b1;
		return t;
	endfunction

	// opcode rules, the signed compare flips both sign bits and compares unsigned
	function automatic logic [`RS_XLEN-1:0] model_result(alu_op_t op, logic sign,
		logic [`RS_XLEN-1:0] a, logic [`RS_XLEN-1:0] b);
		logic [4:0] sh;
		logic [`RS_XLEN-1:0] msb;
		logic [`RS_XLEN-1:0] fill;
		logic lt;
		sh = b[4:0];
		msb = {1'b1, {(`RS_XLEN-1){1'b0}}};
		fill = (sign && a[`RS_XLEN-1]) ? ~({`RS_XLEN{1'b1}} >> sh) : '0;
		lt = sign ? ((a ^ msb) < (b ^ msb)) : (a < b);
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_SLL: return a << sh;
			OP_SLT: return {{(`RS_XLEN-1){1'b0}}, lt};
			OP_XOR: return a ^ b;
			OP_SR: return (a >> sh) | fill;
			OP_OR: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic int total_errors();
		return errors + dut_i.assert_i.full_issue_fails + dut_i.assert_i.zero_tag_fails
			+ dut_i.assert_i.ext_pass_fails + dut_i.assert_i.reissue_fails
			+ dut_i.assert_i.extra_bcast_fails;
	endfunction

	// inputs change 10 ns after the edge, strobes last a single cycle
	task automatic next_cycle();
		@(posedge clk);
		#10;
		issue_valid = 1'b0;
		ext_cdb_active = 1'b0;
	endtask

	// a tagged operand takes its model value from the producing tag
	task automatic issue(input alu_op_t op, input logic sign,
		input logic [`RS_TAG_WIDTH-1:0] q1, input logic [`RS_XLEN-1:0] v1,
		input logic [`RS_TAG_WIDTH-1:0] q2, input logic [`RS_XLEN-1:0] v2,
		output logic [`RS_TAG_WIDTH-1:0] tag);
		logic [`RS_XLEN-1:0] a;
		logic [`RS_XLEN-1:0] b;
		while (full)
			next_cycle();
		tag = alloc_tag();
		a = (q1 != '0) ? expected[q1] : v1;
		b = (q2 != '0) ? expected[q2] : v2;
		expected[tag] = model_result(op, sign, a, b);
		outstanding[tag] = 1'b1;
		in_flight++;
		issue_cycle[tag] = cycle;
		issue_q1 = q1;
		issue_v1 = v1;
		issue_q2 = q2;
		issue_v2 = v2;
		issue_op = op;
		issue_sign = sign;
		issue_rob_tag = tag;
		issue_valid = 1'b1;
	endtask

	task automatic new_ext_tag(output logic [`RS_TAG_WIDTH-1:0] tag);
		tag = alloc_tag();
		expected[tag] = xorshift32();
	endtask

	task automatic ext_broadcast(input logic [`RS_TAG_WIDTH-1:0] tag);
		ext_cdb_active = 1'b1;
		ext_cdb_tag = tag;
		ext_cdb_data = expected[tag];
	endtask

	// every issued result has gone out, and its entry freed on that same edge
	task automatic wait_drain();
		while (in_flight != 0)
			next_cycle();
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors_start = total_errors();
	endtask

	task automatic end_test();
		int n;
		n = total_errors() - test_errors_start;
		if (n == 0) begin
			pass_count++;
			$display("test %s passed", test_name);
		end else begin
			fail_count++;
			$display("test %s failed with %0d errors", test_name, n);
		end
	endtask

	// the bus is stable in the middle of the cycle
	always @(negedge clk) begin
		if (rst_n && cdb_active && !ext_cdb_active) begin
			assert (outstanding[cdb_tag]) else begin
				$display("%s: ALU broadcast of tag %0d that is not in flight", test_name, cdb_tag);
				errors++;
			end
			assert (cdb_data == expected[cdb_tag]) else begin
				$display("MISMATCH %s tag %0d expected %h actual %h", test_name, cdb_tag,
					expected[cdb_tag], cdb_data);
				errors++;
			end
			// without contention the result is on the bus two cycles after issue
			if (check_latency)
				assert (cycle - issue_cycle[cdb_tag] == 2) else begin
					$display("MISMATCH %s latency of tag %0d expected 2 actual %0d", test_name,
						cdb_tag, cycle - issue_cycle[cdb_tag]);
					errors++;
				end
			if (outstanding[cdb_tag]) begin
				outstanding[cdb_tag] = 1'b0;
				in_flight--;
			end
		end
		if (rst_n && ext_cdb_active)
			assert (cdb_active && cdb_tag == ext_cdb_tag && cdb_data == ext_cdb_data) else begin
				$display("MISMATCH %s external tag %0d expected %h actual %h", test_name,
					ext_cdb_tag, ext_cdb_data, cdb_data);
				errors++;
			end
	end

	task automatic test_idle();
		start_test("idle after reset");
		repeat (5) begin
			assert (!cdb_active && !full) else begin
				$display("%s: CDB or full is active with nothing issued", test_name);
				errors++;
			end
			next_cycle();
		end
		end_test();
	endtask

	task automatic test_opcodes();
		logic [`RS_TAG_WIDTH-1:0] t;
		alu_op_t op;
		logic sign;
		logic [`RS_XLEN-1:0] a;
		logic [`RS_XLEN-1:0] b;
		start_test("all opcodes");
		check_latency = 1'b1;
		for (int i = 0; i < 10; i++) begin
			// the last two repeat OP_SLT and OP_SR with the sign bit set
			op = (i < 8) ? alu_op_t'(i) : ((i == 8) ? OP_SLT : OP_SR);
			sign = (i >= 8);
			a = xorshift32();
			b = xorshift32();
			// signed cases get a negative operand 1 and a positive operand 2 with a
			// nonzero shift amount, so signed and unsigned results always differ
			if (sign) begin
				a[`RS_XLEN-1] = 1'b1;
				b[`RS_XLEN-1] = 1'b0;
				b[4] = 1'b1;
			end
			issue(op, sign, '0, a, '0, b, t);
			next_cycle();
		end
		wait_drain();
		check_latency = 1'b0;
		end_test();
	endtask

	task automatic test_chain();
		logic [`RS_TAG_WIDTH-1:0] prev;
		logic [`RS_TAG_WIDTH-1:0] cur;
		start_test("dependency chain");
		issue(OP_ADD, 1'b0, '0, xorshift32(), '0, xorshift32(), prev);
		next_cycle();
		// back to back, each operand wakes up from a stored tag
		for (int i = 0; i < 5; i++) begin
			issue(alu_op_t'(i), 1'b0, prev, xorshift32(), '0, xorshift32(), cur);
			prev = cur;
			next_cycle();
		end
		// issue lands on the edge where the producer is on the bus
		while (!(cdb_active && cdb_tag == prev))
			next_cycle();
		issue(OP_OR, 1'b0, '0, xorshift32(), prev, xorshift32(), cur);
		next_cycle();
		wait_drain();
		end_test();
	endtask

	task automatic test_ext_operand();
		logic [`RS_TAG_WIDTH-1:0] x;
		logic [`RS_TAG_WIDTH-1:0] t;
		start_test("external operand");
		new_ext_tag(x);
		issue(OP_SUB, 1'b0, x, xorshift32(), '0, xorshift32(), t);
		next_cycle();
		next_cycle();
		ext_broadcast(x);
		next_cycle();
		wait_drain();
		end_test();
	endtask

	task automatic test_ext_priority();
		logic [`RS_TAG_WIDTH-1:0] t;
		logic [`RS_TAG_WIDTH-1:0] e;
		start_test("external priority");
		issue(OP_ADD, 1'b0, '0, xorshift32(), '0, xorshift32(), t);
		next_cycle();
		issue(OP_XOR, 1'b0, '0, xorshift32(), '0, xorshift32(), t);
		next_cycle();
		issue(OP_AND, 1'b0, '0, xorshift32(), '0, xorshift32(), t);
		// the external producer holds the bus while ALU results pile up behind it
		for (int i = 0; i < 4; i++) begin
			new_ext_tag(e);
			ext_broadcast(e);
			next_cycle();
		end
		wait_drain();
		end_test();
	endtask

	task automatic test_fill_drain();
		logic [`RS_TAG_WIDTH-1:0] x;
		logic [`RS_TAG_WIDTH-1:0] t;
		start_test("fill and drain");
		new_ext_tag(x);
		// alternate which operand waits on the external tag
		for (int i = 0; i < 4; i++) begin
			if (i % 2 == 0)
				issue(alu_op_t'(2 * i), 1'b0, x, xorshift32(), '0, xorshift32(), t);
			else
				issue(alu_op_t'(2 * i), 1'b0, '0, xorshift32(), x, xorshift32(), t);
			next_cycle();
		end
		assert (full) else begin
			$display("%s: full stayed low with all four entries busy", test_name);
			errors++;
		end
		ext_broadcast(x);
		next_cycle();
		wait_drain();
		assert (!full) else begin
			$display("%s: full stayed high after every entry drained", test_name);
			errors++;
		end
		end_test();
	endtask

	initial begin
		rst_n = 1'b0;
		issue_valid = 1'b0;
		issue_q1 = '0;
		issue_v1 = '0;
		issue_q2 = '0;
		issue_v2 = '0;
		issue_op = OP_ADD;
		issue_sign = 1'b0;
		issue_rob_tag = '0;
		ext_cdb_active = 1'b0;
		ext_cdb_tag = '0;
		ext_cdb_data = '0;
		rng_state = 32'h18ae;
		tag_counter = `RS_TAG_WIDTH'(1);
		outstanding = '0;
		in_flight = 0;
		errors = 0;
		pass_count = 0;
		fail_count = 0;
		check_latency = 1'b0;
		test_name = "reset";
		repeat (3) @(posedge clk);
		#10;
		rst_n = 1'b1;
		test_idle();
		test_opcodes();
		test_chain();
		test_ext_operand();
		test_ext_priority();
		test_fill_drain();
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0 && total_errors() == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+design
design/rs_pkg.sv
design/exec_if.sv
design/reservation_station.sv
design/rs_dispatch_select.sv
design/alu_unit.sv
design/alu_cluster.sv
tb/alu_cluster_assert.sv
tb/alu_cluster_tb.sv
